// File: mbus_macros.svh
`ifndef MBUS_MACROS_SVH
`define MBUS_MACROS_SVH

// Address and data word widths on the member bus.
`define ADDR_WIDTH 32
`define DATA_WIDTH 32

// Function ID sits in the low bits of both address views.
`define FUNC_WIDTH 4

// Broadcast control channel.
`define CHANNEL_CTRL 4'h0

// Receive buffer entries, a power of two of at least 2.
`define RX_FIFO_DEPTH 4

// Filter credit counter must reach the full depth.
`define CREDIT_WIDTH ($clog2(`RX_FIFO_DEPTH) + 1)

// Layer-side prefix is as wide as the full prefix.
`define PREFIX_WIDTH 20

`endif

// File: mbus_pkg.sv
`include "mbus_macros.svh"

package mbus_pkg;

	// Short address, only the low byte carries meaning.
	typedef struct packed {
		logic [23:0]            unused;
		logic [3:0]             prefix;
		logic [`FUNC_WIDTH-1:0] func;
	} mbus_addr_short_t;

	// Full address, flagged by an all-ones marker in the top nibble.
	typedef struct packed {
		logic [3:0]               marker;
		logic [`PREFIX_WIDTH-1:0] prefix;
		logic [3:0]               rsvd;
		logic [`FUNC_WIDTH-1:0]   func;
	} mbus_addr_full_t;

	// One address word, read either way.
	typedef union packed {
		mbus_addr_short_t short_addr;
		mbus_addr_full_t  full_addr;
	} mbus_addr_u;

endpackage

// File: mbus_rx_filter.sv
`include "mbus_macros.svh"

module mbus_rx_filter
	import mbus_pkg::*;
(
	input  logic                     CLK_EXT,
	input  logic                     RESETn_local,
	input  logic                     node_rx_req,
	input  mbus_addr_u               rx_addr,
	input  logic [`DATA_WIDTH-1:0]   rx_data,
	input  logic                     rx_broadcast,
	input  logic                     rx_fail,
	input  logic                     credit_ret,
	output logic                     node_rx_ack,
	output logic                     push,
	output mbus_addr_u               push_addr,
	output logic [`DATA_WIDTH-1:0]   push_data,
	output logic                     push_broadcast,
	output logic [7:0]               ctrl_count,
	output logic [`DATA_WIDTH-1:0]   ctrl_data
);

	localparam logic [1:0] ST_IDLE     = 2'd0;
	localparam logic [1:0] ST_CLASSIFY = 2'd1;
	localparam logic [1:0] ST_ACK      = 2'd2;
	localparam logic [`CREDIT_WIDTH-1:0] CREDIT_INIT = `RX_FIFO_DEPTH;

	logic [1:0]               state;
	logic                     req_q;
	logic [`CREDIT_WIDTH-1:0] credits;
	logic                     is_ctrl;
	logic                     fire_push;

	// A control message never reaches the layer.
	assign is_ctrl = rx_broadcast && (rx_addr.short_addr.func == `CHANNEL_CTRL);

	assign fire_push = (state == ST_CLASSIFY) && !rx_fail && !is_ctrl && (credits != '0);

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state       <= ST_IDLE;
			req_q       <= 1'b0;
			node_rx_ack <= 1'b0;
			push        <= 1'b0;
			ctrl_count  <= '0;
		end
		else
		begin
			req_q <= node_rx_req;
			push  <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (node_rx_req && !req_q)
						state <= ST_CLASSIFY;
				end
				ST_CLASSIFY:
				begin
					// Forwarded messages wait here until a credit comes back.
					if (rx_fail || is_ctrl || fire_push)
					begin
						node_rx_ack <= 1'b1;
						state       <= ST_ACK;
					end
					if (!rx_fail && is_ctrl)
						ctrl_count <= ctrl_count + 8'd1;
					if (fire_push)
						push <= 1'b1;
				end
				ST_ACK:
				begin
					if (!node_rx_req)
					begin
						node_rx_ack <= 1'b0;
						state       <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
			credits <= CREDIT_INIT;
		else
		begin
			case ({fire_push, credit_ret})
				2'b10:   credits <= credits - 1'b1;
				2'b01:   credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (fire_push)
		begin
			push_addr      <= rx_addr;
			push_data      <= rx_data;
			push_broadcast <= rx_broadcast;
		end
		if ((state == ST_CLASSIFY) && !rx_fail && is_ctrl)
			ctrl_data <= rx_data;
	end

endmodule

// File: mbus_rx_fifo.sv
`include "mbus_macros.svh"

module mbus_rx_fifo
	import mbus_pkg::*;
(
	input  logic                     CLK_EXT,
	input  logic                     RESETn_local,
	input  logic                     push,
	input  mbus_addr_u               push_addr,
	input  logic [`DATA_WIDTH-1:0]   push_data,
	input  logic                     push_broadcast,
	input  logic                     hold_free,
	output logic                     credit_ret,
	output logic                     send,
	output mbus_addr_u               send_addr,
	output logic [`DATA_WIDTH-1:0]   send_data,
	output logic                     send_broadcast
);

	localparam int AW = $clog2(`RX_FIFO_DEPTH);

	mbus_addr_u             mem_addr [`RX_FIFO_DEPTH];
	logic [`DATA_WIDTH-1:0] mem_data [`RX_FIFO_DEPTH];
	logic                   mem_bc   [`RX_FIFO_DEPTH];

	// Pointers carry one wrap bit above the index.
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	logic        cons_credit;
	logic        fifo_empty;
	logic        fire;

	assign fifo_empty = (wr_ptr == rd_ptr);
	assign fire       = !fifo_empty && cons_credit;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			cons_credit <= 1'b1;
			send        <= 1'b0;
			credit_ret  <= 1'b0;
		end
		else
		begin
			send       <= fire;
			credit_ret <= fire;
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (fire)
			begin
				rd_ptr      <= rd_ptr + 1'b1;
				cons_credit <= 1'b0;
			end
			else if (hold_free)
				cons_credit <= 1'b1;
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (push)
		begin
			mem_addr[wr_ptr[AW-1:0]] <= push_addr;
			mem_data[wr_ptr[AW-1:0]] <= push_data;
			mem_bc[wr_ptr[AW-1:0]]   <= push_broadcast;
		end
		if (fire)
		begin
			send_addr      <= mem_addr[rd_ptr[AW-1:0]];
			send_data      <= mem_data[rd_ptr[AW-1:0]];
			send_broadcast <= mem_bc[rd_ptr[AW-1:0]];
		end
	end

endmodule

// File: mbus_layer_if.sv
`include "mbus_macros.svh"

module mbus_layer_if
	import mbus_pkg::*;
(
	input  logic                      CLK_EXT,
	input  logic                      RESETn_local,
	input  logic                      send,
	input  mbus_addr_u                send_addr,
	input  logic [`DATA_WIDTH-1:0]    send_data,
	input  logic                      send_broadcast,
	input  logic                      rx_ack,
	output logic                      hold_free,
	output logic                      rx_req,
	output logic [`DATA_WIDTH-1:0]    rx_data_out,
	output logic [`FUNC_WIDTH-1:0]    rx_func,
	output logic [`PREFIX_WIDTH-1:0]  rx_prefix,
	output logic                      rx_full,
	output logic                      rx_broadcast_out
);

	localparam logic [1:0] ST_IDLE    = 2'd0;
	localparam logic [1:0] ST_REQ     = 2'd1;
	localparam logic [1:0] ST_RELEASE = 2'd2;

	logic [1:0]             state;
	mbus_addr_u             hold_addr;
	logic [`DATA_WIDTH-1:0] hold_data;
	logic                   hold_bc;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
		begin
			state     <= ST_IDLE;
			rx_req    <= 1'b0;
			hold_free <= 1'b0;
		end
		else
		begin
			hold_free <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					if (send)
					begin
						rx_req <= 1'b1;
						state  <= ST_REQ;
					end
				end
				ST_REQ:
				begin
					if (rx_ack)
					begin
						rx_req <= 1'b0;
						state  <= ST_RELEASE;
					end
				end
				ST_RELEASE:
				begin
					// Holding register is free once the layer drops its ack.
					if (!rx_ack)
					begin
						hold_free <= 1'b1;
						state     <= ST_IDLE;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge CLK_EXT)
	begin
		if (send)
		begin
			hold_addr <= send_addr;
			hold_data <= send_data;
			hold_bc   <= send_broadcast;
		end
	end

	// Full address when the marker nibble is all ones.
	assign rx_full          = &hold_addr.full_addr.marker;
	assign rx_prefix        = rx_full ? hold_addr.full_addr.prefix
	                                  : `PREFIX_WIDTH'(hold_addr.short_addr.prefix);
	assign rx_func          = hold_addr.short_addr.func;
	assign rx_data_out      = hold_data;
	assign rx_broadcast_out = hold_bc;

endmodule

// File: mbus_rx_path.sv
`include "mbus_macros.svh"

module mbus_rx_path
	import mbus_pkg::*;
(
	input  logic                      CLK_EXT,
	input  logic                      RESETn_local,
	input  logic                      node_rx_req,
	input  mbus_addr_u                rx_addr,
	input  logic [`DATA_WIDTH-1:0]    rx_data,
	input  logic                      rx_broadcast,
	input  logic                      rx_fail,
	output logic                      node_rx_ack,
	output logic                      rx_req,
	output logic [`DATA_WIDTH-1:0]    rx_data_out,
	output logic [`FUNC_WIDTH-1:0]    rx_func,
	output logic [`PREFIX_WIDTH-1:0]  rx_prefix,
	output logic                      rx_full,
	output logic                      rx_broadcast_out,
	input  logic                      rx_ack,
	output logic [7:0]                ctrl_count,
	output logic [`DATA_WIDTH-1:0]    ctrl_data
);

	logic                   push;
	mbus_addr_u             push_addr;
	logic [`DATA_WIDTH-1:0] push_data;
	logic                   push_broadcast;
	logic                   credit_ret;
	logic                   send;
	mbus_addr_u             send_addr;
	logic [`DATA_WIDTH-1:0] send_data;
	logic                   send_broadcast;
	logic                   hold_free;

	mbus_rx_filter mbus_rx_filter_inst (
		.CLK_EXT        (CLK_EXT),
		.RESETn_local   (RESETn_local),
		.node_rx_req    (node_rx_req),
		.rx_addr        (rx_addr),
		.rx_data        (rx_data),
		.rx_broadcast   (rx_broadcast),
		.rx_fail        (rx_fail),
		.credit_ret     (credit_ret),
		.node_rx_ack    (node_rx_ack),
		.push           (push),
		.push_addr      (push_addr),
		.push_data      (push_data),
		.push_broadcast (push_broadcast),
		.ctrl_count     (ctrl_count),
		.ctrl_data      (ctrl_data)
	);

	mbus_rx_fifo mbus_rx_fifo_inst (
		.CLK_EXT        (CLK_EXT),
		.RESETn_local   (RESETn_local),
		.push           (push),
		.push_addr      (push_addr),
		.push_data      (push_data),
		.push_broadcast (push_broadcast),
		.hold_free      (hold_free),
		.credit_ret     (credit_ret),
		.send           (send),
		.send_addr      (send_addr),
		.send_data      (send_data),
		.send_broadcast (send_broadcast)
	);

	mbus_layer_if mbus_layer_if_inst (
		.CLK_EXT          (CLK_EXT),
		.RESETn_local     (RESETn_local),
		.send             (send),
		.send_addr        (send_addr),
		.send_data        (send_data),
		.send_broadcast   (send_broadcast),
		.rx_ack           (rx_ack),
		.hold_free        (hold_free),
		.rx_req           (rx_req),
		.rx_data_out      (rx_data_out),
		.rx_func          (rx_func),
		.rx_prefix        (rx_prefix),
		.rx_full          (rx_full),
		.rx_broadcast_out (rx_broadcast_out)
	);

endmodule

// File: mbus_rx_checker.sv
`include "mbus_macros.svh"

module mbus_rx_checker (
	input logic CLK_EXT,
	input logic RESETn_local,
	input logic push,
	input logic credit_ret,
	input logic node_rx_req,
	input logic node_rx_ack,
	input logic rx_req,
	input logic rx_ack
);

	// Entries pushed whose credit has not come back yet.
	int in_flight;
	int fail_count = 0;

	always_ff @(posedge CLK_EXT or negedge RESETn_local)
	begin
		if (!RESETn_local)
			in_flight <= 0;
		else
			in_flight <= in_flight + int'(push) - int'(credit_ret);
	end

	push_needs_credit: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		push |-> (in_flight < `RX_FIFO_DEPTH))
	else
	begin
		fail_count++;
		$error("push issued with all filter credits spent");
	end

	req_held_until_ack: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		(rx_req && !rx_ack) |=> rx_req)
	else
	begin
		fail_count++;
		$error("rx_req dropped before rx_ack");
	end

	ack_needs_req: assert property (@(posedge CLK_EXT) disable iff (!RESETn_local)
		$rose(node_rx_ack) |-> node_rx_req)
	else
	begin
		fail_count++;
		$error("node_rx_ack rose without node_rx_req");
	end

endmodule

bind mbus_rx_path mbus_rx_checker mbus_rx_checker_inst (
	.CLK_EXT      (CLK_EXT),
	.RESETn_local (RESETn_local),
	.push         (push),
	.credit_ret   (credit_ret),
	.node_rx_req  (node_rx_req),
	.node_rx_ack  (node_rx_ack),
	.rx_req       (rx_req),
	.rx_ack       (rx_ack)
);

// File: mbus_rx_monitor.sv
`include "mbus_macros.svh"

module mbus_rx_monitor (
	input  logic                     CLK_EXT,
	input  logic                     RESETn_local,
	input  logic                     node_rx_ack,
	input  logic                     rx_req,
	input  logic [`DATA_WIDTH-1:0]   rx_data_out,
	input  logic [`FUNC_WIDTH-1:0]   rx_func,
	input  logic [`PREFIX_WIDTH-1:0] rx_prefix,
	input  logic                     rx_full,
	input  logic                     rx_broadcast_out,
	input  logic [7:0]               ctrl_count,
	input  logic [`DATA_WIDTH-1:0]   ctrl_data,
	output int                       error_count
);

	int                     node_idx[$];
	logic                   node_drop[$];
	logic [7:0]             node_count[$];
	logic [`DATA_WIDTH-1:0] node_cdata[$];
	int                     fwd_idx[$];
	logic [`ADDR_WIDTH-1:0] fwd_addr[$];
	logic [`DATA_WIDTH-1:0] fwd_data[$];
	logic                   fwd_bc[$];
	logic [7:0]             exp_ctrl_count = 8'd0;
	logic [`DATA_WIDTH-1:0] exp_ctrl_data = '0;
	int                     passed = 0;
	int                     failed = 0;
	logic                   req_q = 1'b0;
	logic                   ack_q = 1'b0;

	initial
		error_count = 0;

	function automatic int compare_hex(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("mismatch %s: got 0x%0h, expected 0x%0h", name, got, exp);
			return 1;
		end
		return 0;
	endfunction

	task automatic report(input string label, input int bad);
		if (bad == 0)
		begin
			passed++;
			$display("%s: ok", label);
		end
		else
		begin
			failed++;
			error_count += bad;
			$display("%s: failed", label);
		end
	endtask

	// Called once per case, in file order.
	task automatic expect_case(input int idx, input logic [31:0] addr, input logic [31:0] data,
		input logic bc, input logic fail);
		logic is_ctrl;
		is_ctrl = bc && (addr[3:0] == `CHANNEL_CTRL);
		node_idx.push_back(idx);
		node_drop.push_back(fail || is_ctrl);
		if (!fail && is_ctrl)
		begin
			exp_ctrl_count = exp_ctrl_count + 8'd1;
			exp_ctrl_data  = data;
		end
		node_count.push_back(exp_ctrl_count);
		node_cdata.push_back(exp_ctrl_data);
		if (!fail && !is_ctrl)
		begin
			fwd_idx.push_back(idx);
			fwd_addr.push_back(addr);
			fwd_data.push_back(data);
			fwd_bc.push_back(bc);
		end
	endtask

	task automatic check_idle();
		int bad;
		bad = compare_hex("rx_req", rx_req, 0);
		bad += compare_hex("node_rx_ack", node_rx_ack, 0);
		bad += compare_hex("ctrl_count", ctrl_count, 0);
		report("reset state", bad);
	endtask

	task automatic check_layer();
		int                     idx;
		int                     bad;
		logic [`ADDR_WIDTH-1:0] a;
		logic                   full;
		logic [19:0]            prefix;
		if (fwd_idx.size() == 0)
		begin
			$display("layer request arrived with no message outstanding, data 0x%0h",
				rx_data_out);
			error_count++;
			failed++;
			return;
		end
		idx    = fwd_idx.pop_front();
		a      = fwd_addr.pop_front();
		full   = &a[31:28];
		prefix = full ? a[27:8] : {16'h0, a[7:4]};
		bad = compare_hex("rx_data_out", rx_data_out, fwd_data.pop_front());
		bad += compare_hex("rx_broadcast_out", rx_broadcast_out, fwd_bc.pop_front());
		bad += compare_hex("rx_full", rx_full, full);
		bad += compare_hex("rx_prefix", rx_prefix, prefix);
		bad += compare_hex("rx_func", rx_func, a[3:0]);
		report($sformatf("case %0d forwarded", idx), bad);
	endtask

	task automatic note_node_ack();
		int                     idx;
		int                     bad;
		logic                   drop;
		logic [7:0]             cnt;
		logic [`DATA_WIDTH-1:0] cdata;
		if (node_idx.size() == 0)
		begin
			$display("node acknowledge with no request outstanding");
			error_count++;
			return;
		end
		idx   = node_idx.pop_front();
		drop  = node_drop.pop_front();
		cnt   = node_count.pop_front();
		cdata = node_cdata.pop_front();
		// Control totals settle at the same edge as the acknowledge.
		if (drop)
		begin
			bad = compare_hex("ctrl_count", ctrl_count, cnt);
			if (cnt != 0)
				bad += compare_hex("ctrl_data", ctrl_data, cdata);
			report($sformatf("case %0d dropped at filter", idx), bad);
		end
	endtask

	always @(posedge CLK_EXT)
	begin
		if (RESETn_local && rx_req && !req_q)
			check_layer();
		if (RESETn_local && node_rx_ack && !ack_q)
			note_node_ack();
		req_q <= rx_req;
		ack_q <= node_rx_ack;
	end

	task automatic close_run();
		int bad;
		bad = 0;
		if (fwd_idx.size() != 0)
		begin
			$display("%0d forwarded messages never reached the layer", fwd_idx.size());
			bad++;
		end
		if (node_idx.size() != 0)
		begin
			$display("%0d node requests were never acknowledged", node_idx.size());
			bad++;
		end
		bad += compare_hex("ctrl_count", ctrl_count, exp_ctrl_count);
		if (exp_ctrl_count != 0)
			bad += compare_hex("ctrl_data", ctrl_data, exp_ctrl_data);
		report("control channel totals", bad);
		$display("tests: %0d passed, %0d failed, %0d errors", passed, failed, error_count);
	endtask

endmodule

// File: tb_mbus_rx_path.sv
`include "mbus_macros.svh"

module tb_mbus_rx_path;

	localparam int         CLK_PERIOD      = 20;
	localparam int         CYCLES_PER_CASE = 200;
	localparam logic [7:0] DELAY_RANDOM    = 8'hff;

	logic                     CLK_EXT;
	logic                     RESETn_local;
	logic                     node_rx_req;
	logic [`ADDR_WIDTH-1:0]   rx_addr;
	logic [`DATA_WIDTH-1:0]   rx_data;
	logic                     rx_broadcast;
	logic                     rx_fail;
	logic                     node_rx_ack;
	logic                     rx_req;
	logic [`DATA_WIDTH-1:0]   rx_data_out;
	logic [`FUNC_WIDTH-1:0]   rx_func;
	logic [`PREFIX_WIDTH-1:0] rx_prefix;
	logic                     rx_full;
	logic                     rx_broadcast_out;
	logic                     rx_ack;
	logic [7:0]               ctrl_count;
	logic [`DATA_WIDTH-1:0]   ctrl_data;
	int                       error_count;

	logic [`ADDR_WIDTH-1:0] case_addr[$];
	logic [`DATA_WIDTH-1:0] case_data[$];
	logic                   case_bc[$];
	logic                   case_fail[$];
	int                     layer_delay[$];
	int                     num_cases = 0;
	int                     fwd_total = 0;
	int                     layer_done = 0;
	logic                   loaded = 1'b0;
	logic [31:0]            lfsr = 32'he05e;

	mbus_rx_path mbus_rx_path_inst (
		.CLK_EXT          (CLK_EXT),
		.RESETn_local     (RESETn_local),
		.node_rx_req      (node_rx_req),
		.rx_addr          (rx_addr),
		.rx_data          (rx_data),
		.rx_broadcast     (rx_broadcast),
		.rx_fail          (rx_fail),
		.node_rx_ack      (node_rx_ack),
		.rx_req           (rx_req),
		.rx_data_out      (rx_data_out),
		.rx_func          (rx_func),
		.rx_prefix        (rx_prefix),
		.rx_full          (rx_full),
		.rx_broadcast_out (rx_broadcast_out),
		.rx_ack           (rx_ack),
		.ctrl_count       (ctrl_count),
		.ctrl_data        (ctrl_data)
	);

	mbus_rx_monitor rx_monitor_inst (
		.CLK_EXT          (CLK_EXT),
		.RESETn_local     (RESETn_local),
		.node_rx_ack      (node_rx_ack),
		.rx_req           (rx_req),
		.rx_data_out      (rx_data_out),
		.rx_func          (rx_func),
		.rx_prefix        (rx_prefix),
		.rx_full          (rx_full),
		.rx_broadcast_out (rx_broadcast_out),
		.ctrl_count       (ctrl_count),
		.ctrl_data        (ctrl_data),
		.error_count      (error_count)
	);

	initial
		CLK_EXT = 1'b0;

	always #(CLK_PERIOD / 2) CLK_EXT = ~CLK_EXT;

	// Galois form, polynomial x^32 + x^22 + x^2 + x + 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'h80200003;
		return n;
	endfunction

	task automatic take_random_delay(output int d);
		d = 0;
		for (int b = 0; b < 5; b++)
		begin
			d = (d << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr);
		end
	endtask

	task automatic load_cases();
		int                     fd;
		int                     n;
		int                     d;
		string                  line;
		logic [`ADDR_WIDTH-1:0] a;
		logic [`DATA_WIDTH-1:0] dt;
		logic                   b;
		logic                   f;
		logic [7:0]             dl;
		fd = $fopen("mbus_rx_cases.txt", "r");
		if (fd == 0)
			return;
		while (!$feof(fd))
		begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line[0] == "#")
				continue;
			if ($sscanf(line, "%h %h %h %h %h", a, dt, b, f, dl) != 5)
				continue;
			case_addr.push_back(a);
			case_data.push_back(dt);
			case_bc.push_back(b);
			case_fail.push_back(f);
			rx_monitor_inst.expect_case(num_cases, a, dt, b, f);
			num_cases++;
			// Only forwarded messages reach the layer and use a delay.
			if (!f && !(b && a[3:0] == `CHANNEL_CTRL))
			begin
				if (dl == DELAY_RANDOM)
					take_random_delay(d);
				else
					d = int'(dl);
				layer_delay.push_back(d);
				fwd_total++;
			end
		end
		$fclose(fd);
	endtask

	task automatic send_case(input int idx);
		@(posedge CLK_EXT);
		rx_addr      <= case_addr[idx];
		rx_data      <= case_data[idx];
		rx_broadcast <= case_bc[idx];
		rx_fail      <= case_fail[idx];
		node_rx_req  <= 1'b1;
		do
			@(posedge CLK_EXT);
		while (!node_rx_ack);
		node_rx_req <= 1'b0;
		do
			@(posedge CLK_EXT);
		while (node_rx_ack);
	endtask

	initial
	begin
		int total;
		RESETn_local <= 1'b0;
		node_rx_req  <= 1'b0;
		rx_addr      <= '0;
		rx_data      <= '0;
		rx_broadcast <= 1'b0;
		rx_fail      <= 1'b0;
		load_cases();
		loaded = 1'b1;
		repeat (3) @(posedge CLK_EXT);
		RESETn_local <= 1'b1;
		@(posedge CLK_EXT);
		rx_monitor_inst.check_idle();
		for (int i = 0; i < num_cases; i++)
			send_case(i);
		while (layer_done < fwd_total)
			@(posedge CLK_EXT);
		repeat (4) @(posedge CLK_EXT);
		rx_monitor_inst.close_run();
		total = error_count + mbus_rx_path_inst.mbus_rx_checker_inst.fail_count;
		if (num_cases == 0)
		begin
			$display("no test cases were read from mbus_rx_cases.txt");
			total++;
		end
		if (total == 0)
			$display("TEST PASSED");
		else
			$display("TEST FAILED");
		$finish;
	end

	// Layer side acknowledges each request after that case's delay.
	initial
	begin
		int d;
		rx_ack <= 1'b0;
		forever
		begin
			do
				@(posedge CLK_EXT);
			while (!rx_req);
			d = (layer_delay.size() != 0) ? layer_delay.pop_front() : 0;
			repeat (d) @(posedge CLK_EXT);
			rx_ack <= 1'b1;
			do
				@(posedge CLK_EXT);
			while (rx_req);
			rx_ack <= 1'b0;
			layer_done++;
		end
	end

	initial
	begin
		wait (loaded);
		repeat (CYCLES_PER_CASE * num_cases + 50) @(posedge CLK_EXT);
		$display("timeout: the run did not finish within %0d cycles per case", CYCLES_PER_CASE);
		$display("TEST FAILED");
		$finish;
	end

endmodule

// File: mbus_rx_cases.txt
# address  data  broadcast  fail  layer_delay (hex; delay ff takes a random delay)
# Channel 0 broadcasts are control messages and never reach the layer.
00000012 a5a50001 0 0 02
f1234b53 a5a50002 0 0 00
00000000 c0de0001 1 0 00
00000035 dead0003 0 1 00
0000002a a5a50004 1 0 03
7ff00042 a5a50005 0 0 ff
fabcde07 a5a50006 0 0 ff
00000000 c0de0002 1 0 00
00000061 b0b00001 0 0 28
f0000162 b0b00002 0 0 28
00000063 b0b00003 0 0 28
00000064 b0b00004 0 0 28
f00abc65 b0b00005 0 0 28
00000066 b0b00006 0 0 28
000000f9 b0b00007 1 1 00

// File: list.f
+incdir+.
mbus_pkg.sv
mbus_rx_filter.sv
mbus_rx_fifo.sv
mbus_layer_if.sv
mbus_rx_path.sv
mbus_rx_checker.sv
mbus_rx_monitor.sv
tb_mbus_rx_path.sv

// File: Bender.yml
package:
  name: mbus_rx_path

sources:
  - include_dirs:
      - .
    files:
      - mbus_pkg.sv
      - mbus_rx_filter.sv
      - mbus_rx_fifo.sv
      - mbus_layer_if.sv
      - mbus_rx_path.sv
  - target: test
    include_dirs:
      - .
    files:
      - mbus_rx_checker.sv
      - mbus_rx_monitor.sv
      - tb_mbus_rx_path.sv
